/* sim.f */
+incdir+.
tracePkg.sv
traceIf.sv
recordDispatch.sv
framePacketizer.sv
burstMerger.sv
traceExportTop.sv
traceExportChecks.sv
tbTraceExport.sv

/* tbTraceExport.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for traceExportTop with frame checks in traceExportChecks
// Stimulus comes from seeded $random and repeats from run to run
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "traceCfg_cfg.svh"

module tbTraceExport;

  localparam int RecBits       = `TRACE_RECORD_BITS;
  localparam int TimeoutCycles = 2000;

  logic               m_axi_aclk;
  logic               m_axi_aresetn;
  logic [RecBits-1:0] record;
  logic               recordValid;
  logic               recordStall;
  logic [31:0]        wData;
  logic               wLast;
  logic               wValid;
  logic               wReady;
  logic               stallSeen;
  logic               readyRandom;
  int                 errorCount;
  int                 frameCount;
  int                 pendingCount;
  int                 seed;
  int                 readySeed;
  int                 testsRun;
  int                 testsFailed;
  int                 acceptTotal;
  int                 errorsBefore;
  bit                 sentOk;
  bit                 drainOk;

  initial m_axi_aclk = 1'b0;
  always #2 m_axi_aclk = ~m_axi_aclk;

  traceExportTop u_dut (
    .m_axi_aclk    (m_axi_aclk),
    .m_axi_aresetn (m_axi_aresetn),
    .record        (record),
    .recordValid   (recordValid),
    .recordStall   (recordStall),
    .wData         (wData),
    .wLast         (wLast),
    .wValid        (wValid),
    .wReady        (wReady)
  );

  traceExportChecks u_checks (
    .m_axi_aclk, .m_axi_aresetn, .record, .recordValid, .recordStall,
    .wData, .wLast, .wValid, .wReady,
    .errorCount, .frameCount, .pendingCount, .stallSeen
  );

  function automatic bit coinFlip();
    return ($random(seed) & 1) != 0;
  endfunction

  function automatic logic [RecBits-1:0] randomRecord();
    logic [RecBits-1:0] value;
    for (int w = 0; w < `TRACE_RECORD_WORDS; w++) value[w*32 +: 32] = $random(seed);
    return value;
  endfunction

  // W sink that is always ready or stalls at random
  always @(posedge m_axi_aclk) begin
    if (m_axi_aresetn) wReady <= readyRandom ? (($random(readySeed) & 1) != 0) : 1'b1;
  end

  // Offer one record until it is accepted
  task automatic pushRecord(input bit gapRandom, output bit accepted);
    int waitCycles;
    waitCycles  = 0;
    accepted    = 1'b0;
    record      <= randomRecord();
    recordValid <= gapRandom ? coinFlip() : 1'b1;
    while (!accepted && waitCycles < TimeoutCycles) begin
      @(posedge m_axi_aclk);
      if (recordValid && !recordStall) begin
        accepted = 1'b1;
      end else begin
        waitCycles++;
        if (gapRandom) recordValid <= coinFlip();
      end
    end
  endtask

  task automatic sendRecords(input int count, input bit gapRandom, output bit ok);
    bit accepted;
    ok = 1'b1;
    for (int n = 0; n < count && ok; n++) begin
      pushRecord(gapRandom, accepted);
      if (accepted) begin
        acceptTotal++;
      end else begin
        $display("Timeout waiting for record %0d to be accepted", n);
        ok = 1'b0;
      end
    end
    recordValid <= 1'b0;
  endtask

  task automatic waitFrames(input int target, output bit ok);
    int waitCycles;
    waitCycles = 0;
    while (frameCount < target && waitCycles < TimeoutCycles) begin
      @(posedge m_axi_aclk);
      waitCycles++;
    end
    ok = (frameCount >= target);
    if (!ok) $display("Timeout waiting for frame %0d on the W channel", target);
  endtask

  task automatic reportTest(input string name, input bit ok);
    bit failed;
    failed = !ok || (errorCount != errorsBefore);
    testsRun++;
    if (failed) testsFailed++;
    $display("Test %0d %s %s", testsRun, name, failed ? "failed" : "passed");
    errorsBefore = errorCount;
  endtask

  // Hard stop in case a wait loop itself never returns
  initial begin
    #200000;
    $display("Simulation watchdog expired");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    seed          = 32'heaf4;
    readySeed     = ~seed;
    m_axi_aresetn = 1'b0;
    record        = '0;
    recordValid   = 1'b0;
    wReady        = 1'b0;
    readyRandom   = 1'b0;
    testsRun      = 0;
    testsFailed   = 0;
    acceptTotal   = 0;
    errorsBefore  = 0;
    repeat (4) @(posedge m_axi_aclk);
    m_axi_aresetn <= 1'b1;

    // Idle outputs right after reset
    repeat (8) @(posedge m_axi_aclk);
    reportTest("resetQuiet", 1'b1);

    sendRecords(1, 1'b0, sentOk);
    waitFrames(acceptTotal, drainOk);
    reportTest("singleFrame", sentOk && drainOk);

    // Back-to-back through every lane and past the wrap
    sendRecords(2 * `TRACE_LANES - 1, 1'b0, sentOk);
    waitFrames(acceptTotal, drainOk);
    reportTest("laneSweep", sentOk && drainOk);

    readyRandom <= 1'b1;
    sendRecords(40, 1'b1, sentOk);
    waitFrames(acceptTotal, drainOk);
    if (!stallSeen) begin
      $display("recordStall never rose while every lane was busy");
    end
    if (frameCount != acceptTotal) begin
      $display("** Error @%0t: frameCount = %0d, expected %0d",
               $time, frameCount, acceptTotal);
    end
    if (pendingCount != 0) begin
      $display("** Error @%0t: pendingCount = %0d, expected 0", $time, pendingCount);
    end
    reportTest("backPressure", sentOk && drainOk && stallSeen &&
               frameCount == acceptTotal && pendingCount == 0);

    $display("Tests %0d, failed %0d, assertion errors %0d, records %0d, frames %0d",
             testsRun, testsFailed, errorCount, acceptTotal, frameCount);
    if (testsFailed == 0 && errorCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* traceExportChecks.sv */
////////////////////////////////////////////////////////////////////////////
// Scoreboard and protocol assertions on the top-level trace export ports
// Records are queued on accept, beats are matched against the queue head
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "traceCfg_cfg.svh"

module traceExportChecks (
  input  logic                          m_axi_aclk,
  input  logic                          m_axi_aresetn,
  input  logic [`TRACE_RECORD_BITS-1:0] record,
  input  logic                          recordValid,
  input  logic                          recordStall,
  input  logic [31:0]                   wData,
  input  logic                          wLast,
  input  logic                          wValid,
  input  logic                          wReady,
  output int                            errorCount,
  output int                            frameCount,
  output int                            pendingCount,
  output logic                          stallSeen
);

  localparam int FrameWords = `TRACE_FRAME_WORDS;

  logic [`TRACE_RECORD_BITS-1:0] recQ [$];
  logic [`TRACE_RECORD_BITS-1:0] headRec;
  logic [31:0]                   seqModel;
  logic [31:0]                   expWord;
  logic [31:0]                   heldData;
  logic                          heldLast;
  logic                          acceptedAny;
  int                            beatIdx;

  // Expected frame word from the frame layout
  function automatic logic [31:0] frameWord(input int idx,
                                            input logic [`TRACE_RECORD_BITS-1:0] rec,
                                            input logic [31:0] seq);
    logic [47:0] dst;
    logic [47:0] src;
    dst = `TRACE_DST_MAC;
    src = `TRACE_SRC_MAC;
    if (idx == 0) return dst[31:0];
    // Dst high half in the low bits, src low half above it
    if (idx == 1) return {src[15:0], dst[47:32]};
    if (idx == 2) return src[47:16];
    if (idx == 3) return {16'(`TRACE_FRAME_BYTES), `TRACE_ETH_TYPE};
    if (idx < 4 + `TRACE_RECORD_WORDS) return rec[(idx - 4) * 32 +: 32];
    return seq;
  endfunction

  assign expWord = frameWord(beatIdx, headRec, seqModel);

  initial errorCount = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      recQ.delete();
      headRec      <= '0;
      seqModel     <= '0;
      beatIdx      <= 0;
      frameCount   <= 0;
      pendingCount <= 0;
      acceptedAny  <= 1'b0;
      stallSeen    <= 1'b0;
    end else begin
      if (recordValid && !recordStall) begin
        recQ.push_back(record);
        acceptedAny <= 1'b1;
      end
      if (wValid && wReady) begin
        if (wLast) begin
          // Frame done so its record retires
          if (recQ.size() > 0) void'(recQ.pop_front());
          beatIdx    <= 0;
          seqModel   <= seqModel + 32'd1;
          frameCount <= frameCount + 1;
        end else begin
          beatIdx <= beatIdx + 1;
        end
      end
      // Stall while every lane and the buffer hold a record
      if (recordStall && recQ.size() > `TRACE_LANES) stallSeen <= 1'b1;
      headRec      <= (recQ.size() > 0) ? recQ[0] : '0;
      pendingCount <= recQ.size();
    end
    heldData <= wData;
    heldLast <= wLast;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Quiet outputs until the first record goes in
  aQuiet: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    !acceptedAny |-> (!wValid && !recordStall))
    else begin
      errorCount++;
      $display("** Error @%0t: wValid = %b, recordStall = %b, expected 0 and 0",
               $time, $sampled(wValid), $sampled(recordStall));
    end

  // Header, payload and trailer content
  aWord: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    (wValid && wReady) |-> (wData == expWord))
    else begin
      errorCount++;
      $display("** Error @%0t: wData (beat %0d) = %h, expected %h",
               $time, $sampled(beatIdx), $sampled(wData), $sampled(expWord));
    end

  // Burst length and last marker
  aLast: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    (wValid && wReady) |-> (wLast == (beatIdx == FrameWords - 1)))
    else begin
      errorCount++;
      $display("** Error @%0t: wLast (beat %0d) = %b, expected %b", $time,
               $sampled(beatIdx), $sampled(wLast), $sampled(beatIdx) == FrameWords - 1);
    end

  aOrphan: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    (wValid && wReady) |-> (pendingCount > 0))
    else begin
      errorCount++;
      $display("A beat left on W with no accepted record waiting at %0t", $time);
    end

  // Stalled beat held intact
  aHold: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    (wValid && !wReady) |=> (wValid && $stable(wData) && $stable(wLast)))
    else begin
      errorCount++;
      $display("** Error @%0t: wData = %h, wLast = %b, expected held %h and %b (wValid %b)",
               $time, $sampled(wData), $sampled(wLast), $sampled(heldData),
               $sampled(heldLast), $sampled(wValid));
    end

endmodule

/* traceExportTop.sv */
////////////////////////////////////////////////////////////////////////////
// Trace export top, records in and framed AXI4 W bursts out
// AW and B are not handled, strobes are implicitly all ones
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "traceCfg_cfg.svh"

module traceExportTop (
  input  logic                          m_axi_aclk,
  input  logic                          m_axi_aresetn,
  // Core trace side
  input  logic [`TRACE_RECORD_BITS-1:0] record,
  input  logic                          recordValid,
  output logic                          recordStall,
  // AXI4 write data channel
  output logic [31:0]                   wData,
  output logic                          wLast,
  output logic                          wValid,
  input  logic                          wReady
);

  // One link pair per lane
  recordLink recLinks  [`TRACE_LANES] ();
  beatLink   beatLinks [`TRACE_LANES] ();

  // Record buffer and lane hand-out
  recordDispatch u_dispatch (
    .m_axi_aclk    (m_axi_aclk),
    .m_axi_aresetn (m_axi_aresetn),
    .record        (record),
    .recordValid   (recordValid),
    .recordStall   (recordStall),
    .lanes         (recLinks)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Framing lanes
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < `TRACE_LANES; g++) begin : gPack
    framePacketizer u_pack (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .rec           (recLinks[g]),
      .beats         (beatLinks[g])
    );
  end

  // Same round-robin order as the dispatcher keeps frames in order
  burstMerger u_merge (
    .m_axi_aclk    (m_axi_aclk),
    .m_axi_aresetn (m_axi_aresetn),
    .lanes         (beatLinks),
    .wData         (wData),
    .wLast         (wLast),
    .wValid        (wValid),
    .wReady        (wReady)
  );

endmodule

/* burstMerger.sv */
////////////////////////////////////////////////////////////////////////////
// Round-robin drain of lane bursts onto the single W channel
// Grant moves only on a last beat, so a slow lane blocks the others
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "traceCfg_cfg.svh"

module burstMerger (
  input  logic        m_axi_aclk,
  input  logic        m_axi_aresetn,
  beatLink.sink       lanes [`TRACE_LANES],
  output logic [31:0] wData,
  output logic        wLast,
  output logic        wValid,
  input  logic        wReady
);

  localparam int PtrBits = (`TRACE_LANES > 1) ? $clog2(`TRACE_LANES) : 1;

  logic [PtrBits-1:0]      grant;
  logic [31:0]             laneData [`TRACE_LANES];
  logic [`TRACE_LANES-1:0] laneLast;
  logic [`TRACE_LANES-1:0] laneValid;
  logic                    burstEnd;

  ////////////////////////////////////////////////////////////////////////////
  // Lane gather and ready return
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `TRACE_LANES; i++) begin : gLane
    assign laneData[i]  = lanes[i].data;
    assign laneLast[i]  = lanes[i].last;
    assign laneValid[i] = lanes[i].valid;
    // Non-granted lanes always see back-pressure
    assign lanes[i].ready = wReady && (grant == PtrBits'(i));
  end

  // Granted lane straight through to W
  assign wData  = laneData[grant];
  assign wLast  = laneLast[grant];
  assign wValid = laneValid[grant];

  // Final beat of the current burst accepted
  assign burstEnd = wValid && wReady && wLast;

  ////////////////////////////////////////////////////////////////////////////
  // Grant pointer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      grant <= '0;
    end else if (burstEnd) begin
      if (grant == PtrBits'(`TRACE_LANES - 1)) begin
        grant <= '0;
      end else begin
        grant <= grant + 1'b1;
      end
    end
  end

  // The granted lane keeps W valid until its burst ends
  assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    (wValid && !burstEnd) |=> wValid);

endmodule

/* framePacketizer.sv */
////////////////////////////////////////////////////////////////////////////
// One framing lane, holds a single record from ack until its last beat
// Header word 3 carries EthType in bits 15:0 and length in bits 31:16
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "traceCfg_cfg.svh"

module framePacketizer (
  input  logic      m_axi_aclk,
  input  logic      m_axi_aresetn,
  recordLink.sink   rec,
  beatLink.source   beats
);

  localparam int CntBits = $clog2(`TRACE_FRAME_WORDS + 1);
  localparam logic [47:0] DstMac = `TRACE_DST_MAC;
  localparam logic [47:0] SrcMac = `TRACE_SRC_MAC;
  localparam logic [15:0] FrameLen = 16'(`TRACE_FRAME_BYTES);

  tracePkg::laneState            state;
  logic [`TRACE_RECORD_BITS-1:0] recReg;
  logic [31:0]                   seqReg;
  logic [CntBits-1:0]            wordCount;
  logic [CntBits-1:0]            recIdx;
  logic                          beatDone;

  assign rec.ack     = (state == tracePkg::laneAcked);
  assign beats.valid = (state == tracePkg::laneSend);
  assign beats.last  = (wordCount == CntBits'(`TRACE_FRAME_WORDS - 1));
  assign beatDone    = beats.valid && beats.ready;

  // Payload word index once past the header
  assign recIdx = wordCount - CntBits'(4);

  ////////////////////////////////////////////////////////////////////////////
  // Beat select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (wordCount)
      CntBits'(0): beats.data = DstMac[31:0];
      // Dst high half low, src low half high
      CntBits'(1): beats.data = {SrcMac[15:0], DstMac[47:32]};
      CntBits'(2): beats.data = SrcMac[47:16];
      CntBits'(3): beats.data = {FrameLen, `TRACE_ETH_TYPE};
      default: begin
        if (wordCount < CntBits'(4 + `TRACE_RECORD_WORDS)) begin
          // Record words, least significant first
          beats.data = recReg[recIdx*32 +: 32];
        end else begin
          // Trailer
          beats.data = seqReg;
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lane FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      state     <= tracePkg::laneIdle;
      wordCount <= '0;
    end else begin
      case (state)
        tracePkg::laneIdle: begin
          if (rec.req) begin
            state <= tracePkg::laneAcked;
          end
        end
        tracePkg::laneAcked: begin
          // Dispatcher released req, start the frame
          if (!rec.req) begin
            state     <= tracePkg::laneSend;
            wordCount <= '0;
          end
        end
        tracePkg::laneSend: begin
          if (beatDone) begin
            if (beats.last) begin
              state     <= tracePkg::laneIdle;
              wordCount <= '0;
            end else begin
              wordCount <= wordCount + 1'b1;
            end
          end
        end
        default: begin
          state <= tracePkg::laneIdle;
        end
      endcase
    end
  end

  // Record and sequence latch at the request seen in idle
  always_ff @(posedge m_axi_aclk) begin
    if (state == tracePkg::laneIdle && rec.req) begin
      recReg <= rec.record;
      seqReg <= rec.seq;
    end
  end

  // A stalled beat is held intact until the merger takes it
  assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    (beats.valid && !beats.ready) |=>
      (beats.valid && $stable(beats.data) && $stable(beats.last)));

endmodule

/* recordDispatch.sv */
////////////////////////////////////////////////////////////////////////////
// One-deep record buffer handed to lanes in strict round-robin order
// A busy lane stalls the buffer, later lanes are never skipped to
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "traceCfg_cfg.svh"

module recordDispatch (
  input  logic                          m_axi_aclk,
  input  logic                          m_axi_aresetn,
  input  logic [`TRACE_RECORD_BITS-1:0] record,
  input  logic                          recordValid,
  output logic                          recordStall,
  recordLink.source                     lanes [`TRACE_LANES]
);

  localparam int PtrBits = (`TRACE_LANES > 1) ? $clog2(`TRACE_LANES) : 1;

  tracePkg::handState            state;
  logic [`TRACE_RECORD_BITS-1:0] bufRecord;
  logic [PtrBits-1:0]            lanePtr;
  logic [31:0]                   seqCount;
  logic [`TRACE_LANES-1:0]       ackVec;
  logic                          ackSel;

  // Buffer is full in every state but empty
  assign recordStall = (state != tracePkg::handEmpty);

  ////////////////////////////////////////////////////////////////////////////
  // Lane fan-out
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `TRACE_LANES; i++) begin : gLane
    // Only the pointed lane sees req
    assign lanes[i].req    = (state == tracePkg::handRequest) && (lanePtr == PtrBits'(i));
    assign lanes[i].record = bufRecord;
    assign lanes[i].seq    = seqCount;
    assign ackVec[i]       = lanes[i].ack;

    // Ack only comes from the lane being served while the buffer is full
    assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
      lanes[i].ack |-> (recordStall && (lanePtr == PtrBits'(i))));
  end

  assign ackSel = ackVec[lanePtr];

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      state    <= tracePkg::handEmpty;
      lanePtr  <= '0;
      seqCount <= '0;
    end else begin
      case (state)
        tracePkg::handEmpty: begin
          if (recordValid) begin
            state <= tracePkg::handRequest;
          end
        end
        tracePkg::handRequest: begin
          // Lane latched the record
          if (ackSel) begin
            state <= tracePkg::handRelease;
          end
        end
        tracePkg::handRelease: begin
          // Exchange complete, move on to the next lane
          if (!ackSel) begin
            state    <= tracePkg::handEmpty;
            seqCount <= seqCount + 32'd1;
            if (lanePtr == PtrBits'(`TRACE_LANES - 1)) begin
              lanePtr <= '0;
            end else begin
              lanePtr <= lanePtr + 1'b1;
            end
          end
        end
        default: begin
          state <= tracePkg::handEmpty;
        end
      endcase
    end
  end

  // Payload buffer, loaded on accept
  always_ff @(posedge m_axi_aclk) begin
    if (!recordStall && recordValid) begin
      bufRecord <= record;
    end
  end

endmodule

/* traceIf.sv */
////////////////////////////////////////////////////////////////////////////
// Point-to-point links between dispatcher, lanes and merger
// recordLink is a four-phase req/ack link, beatLink a valid/ready stream
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "traceCfg_cfg.svh"

// Dispatcher to lane, one record per handshake
interface recordLink;
  logic                          req;
  logic                          ack;
  logic [`TRACE_RECORD_BITS-1:0] record;
  // Frame sequence number travelling with the record
  logic [31:0]                   seq;

  // Dispatcher side
  modport source (
    output req,
    output record,
    output seq,
    input  ack
  );

  // Lane side
  modport sink (
    input  req,
    input  record,
    input  seq,
    output ack
  );
endinterface

// Lane to merger, one 32-bit beat per transfer
interface beatLink;
  logic [31:0] data;
  logic        last;
  logic        valid;
  logic        ready;

  modport source (
    output data,
    output last,
    output valid,
    input  ready
  );

  modport sink (
    input  data,
    input  last,
    input  valid,
    output ready
  );
endinterface

/* tracePkg.sv */
////////////////////////////////////////////////////////////////////////////
// State encodings shared by the trace export RTL
// Both enums are 2 bits wide, one code of each is unused
////////////////////////////////////////////////////////////////////////////

package tracePkg;

  //////////////////////////////////////////////////////////////////////////
  // Packetizer lane
  //////////////////////////////////////////////////////////////////////////

  // laneIdle   waiting for a record request
  // laneAcked  record latched, ack held until req drops
  // laneSend   streaming the frame beats
  typedef enum logic [1:0] {
    laneIdle  = 2'd0,
    laneAcked = 2'd1,
    laneSend  = 2'd2
  } laneState;

  //////////////////////////////////////////////////////////////////////////
  // Dispatcher handshake
  //////////////////////////////////////////////////////////////////////////

  // handEmpty    buffer free, new records accepted
  // handRequest  req high to the pointed lane
  // handRelease  req dropped, waiting for ack to fall
  typedef enum logic [1:0] {
    handEmpty   = 2'd0,
    handRequest = 2'd1,
    handRelease = 2'd2
  } handState;

endpackage

/* traceCfg_cfg.svh */
////////////////////////////////////////////////////////////////////////////
// Build-time configuration of the trace export block
// TRACE_RECORD_BITS must be a non-zero multiple of 32
// MAC addresses and EthType are fixed constants, not programmable
////////////////////////////////////////////////////////////////////////////

`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// Width of one retired-instruction record
`define TRACE_RECORD_BITS 96

// Number of packetizer lanes behind the dispatcher
`define TRACE_LANES 4

// Record payload in 32-bit words
`define TRACE_RECORD_WORDS (`TRACE_RECORD_BITS / 32)

// Four header words, the payload and one sequence trailer
`define TRACE_FRAME_WORDS (`TRACE_RECORD_WORDS + 5)

// Value carried in the header length field
`define TRACE_FRAME_BYTES (`TRACE_FRAME_WORDS * 4)

// Frame addressing
`define TRACE_DST_MAC 48'h8F54_0000_1654
`define TRACE_SRC_MAC 48'h4502_1111_6843
`define TRACE_ETH_TYPE 16'h0801

`endif
